// File: src/nn_pkg.sv
`default_nettype none

package nn_pkg;

  // default word width in bits
  parameter int WORD_SIZE_DEF = 16;

  // default number of packed channels per vector
  parameter int NUM_CHANNELS_DEF = 4;

  // saturating alu operations
  // neg is used by the abs layer, add by the bias layer
  typedef enum logic [1:0] {
    ALU_NEG = 2'd0,
    ALU_ADD = 2'd1
  } alu_op_e;

endpackage

`default_nettype wire

// File: src/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // occupancy of the one-entry layer register
  typedef enum logic {
    ST_EMPTY = 1'b0,
    ST_FULL  = 1'b1
  } fifo_state_e;

endpackage

`default_nettype wire

// File: src/safe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module safe_alu #(
  parameter int WORD_SIZE = 16
) (
  input  logic signed [WORD_SIZE-1:0] a_i,
  input  logic signed [WORD_SIZE-1:0] b_i,
  input  nn_pkg::alu_op_e             op_i,
  output logic signed [WORD_SIZE-1:0] data_o
);

  // clamp limits of the signed range
  localparam logic signed [WORD_SIZE-1:0] MAX_VAL = {1'b0, {(WORD_SIZE-1){1'b1}}};
  localparam logic signed [WORD_SIZE-1:0] MIN_VAL = {1'b1, {(WORD_SIZE-1){1'b0}}};

  // sum with one guard bit
  logic [WORD_SIZE:0] sum_ext;
  // top two bits of the guarded sum disagree on overflow
  logic               add_ovf;

  // sign extend both operands before adding
  assign sum_ext = {a_i[WORD_SIZE-1], a_i} + {b_i[WORD_SIZE-1], b_i};
  assign add_ovf = sum_ext[WORD_SIZE] ^ sum_ext[WORD_SIZE-1];

  always_comb begin
    case (op_i)
      nn_pkg::ALU_NEG: begin
        // most negative code has no positive twin
        if (a_i == MIN_VAL) begin
          data_o = MAX_VAL;
        end else begin
          data_o = -a_i;
        end
      end
      nn_pkg::ALU_ADD: begin
        if (add_ovf) begin
          // guard bit holds the true sign
          if (sum_ext[WORD_SIZE]) begin
            data_o = MIN_VAL;
          end else begin
            data_o = MAX_VAL;
          end
        end else begin
          data_o = sum_ext[WORD_SIZE-1:0];
        end
      end
      default: begin
        // unused opcodes pass a through
        data_o = a_i;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/single_fifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module single_fifo_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,

  // upstream side
  input  logic valid_i,
  output logic ready_o,

  // downstream side
  output logic valid_o,
  input  logic ready_i,

  // load enable for the data register
  output logic en_o
);

  ctrl_pkg::fifo_state_e state_q;
  ctrl_pkg::fifo_state_e state_d;

  // transfers on each side
  logic in_xfer;
  logic out_xfer;

  // register holds a word only when full
  assign valid_o = (state_q == ctrl_pkg::ST_FULL);

  // helpful consumer
  // accept when empty or when the held word leaves this cycle
  assign ready_o = (state_q == ctrl_pkg::ST_EMPTY) | ready_i;

  assign in_xfer  = valid_i & ready_o;
  assign out_xfer = valid_o & ready_i;

  // load on every accepted word
  assign en_o = in_xfer;

  always_comb begin
    state_d = state_q;
    if (in_xfer) begin
      // new word in, possibly replacing a leaving one
      state_d = ctrl_pkg::ST_FULL;
    end else if (out_xfer) begin
      // drained with nothing behind it
      state_d = ctrl_pkg::ST_EMPTY;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ctrl_pkg::ST_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: src/abs_layer.sv
`timescale 1ns/1ps
`default_nettype none

module abs_layer #(
  parameter int WORD_SIZE    = 16,
  parameter int NUM_CHANNELS = 1
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,

  // from previous stage
  input  logic                                    valid_i,
  output logic                                    ready_o,
  input  logic signed [NUM_CHANNELS*WORD_SIZE-1:0] data_i,

  // to next stage
  output logic                                    valid_o,
  input  logic                                    ready_i,
  output logic signed [NUM_CHANNELS*WORD_SIZE-1:0] data_o
);

  // register load enable
  logic en;

  // saturated negation per channel
  logic signed [WORD_SIZE-1:0] neg_w [NUM_CHANNELS];

  single_fifo_ctrl u_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .en_o     (en)
  );

  // one negating alu per channel, b operand unused
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
    safe_alu #(
      .WORD_SIZE (WORD_SIZE)
    ) u_alu (
      .a_i    (data_i[g*WORD_SIZE +: WORD_SIZE]),
      .b_i    ('0),
      .op_i   (nn_pkg::ALU_NEG),
      .data_o (neg_w[g])
    );
  end

  // msb is the sign
  // negative words take the negation, others pass as is
  always_ff @(posedge clk_i) begin
    if (en) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        if (data_i[c*WORD_SIZE + WORD_SIZE - 1]) begin
          data_o[c*WORD_SIZE +: WORD_SIZE] <= neg_w[c];
        end else begin
          data_o[c*WORD_SIZE +: WORD_SIZE] <= data_i[c*WORD_SIZE +: WORD_SIZE];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/bias_layer.sv
`timescale 1ns/1ps
`default_nettype none

module bias_layer #(
  parameter int WORD_SIZE    = 16,
  parameter int NUM_CHANNELS = 1
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,

  // from previous stage
  input  logic                                    valid_i,
  output logic                                    ready_o,
  input  logic signed [NUM_CHANNELS*WORD_SIZE-1:0] data_i,

  // static per channel bias
  // held steady while words are in flight
  input  logic signed [NUM_CHANNELS*WORD_SIZE-1:0] bias_i,

  // to next stage
  output logic                                    valid_o,
  input  logic                                    ready_i,
  output logic signed [NUM_CHANNELS*WORD_SIZE-1:0] data_o
);

  // register load enable
  logic en;

  // saturated data plus bias per channel
  logic signed [WORD_SIZE-1:0] sum_w [NUM_CHANNELS];

  single_fifo_ctrl u_ctrl (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .en_o     (en)
  );

  // adder per channel
  // each bias slice only meets its own data slice
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
    safe_alu #(
      .WORD_SIZE (WORD_SIZE)
    ) u_alu (
      .a_i    (data_i[g*WORD_SIZE +: WORD_SIZE]),
      .b_i    (bias_i[g*WORD_SIZE +: WORD_SIZE]),
      .op_i   (nn_pkg::ALU_ADD),
      .data_o (sum_w[g])
    );
  end

  // output register, loads on accepted word only
  always_ff @(posedge clk_i) begin
    if (en) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        data_o[c*WORD_SIZE +: WORD_SIZE] <= sum_w[c];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/layer_chain.sv
`timescale 1ns/1ps
`default_nettype none

module layer_chain #(
  parameter int WORD_SIZE    = nn_pkg::WORD_SIZE_DEF,
  parameter int NUM_CHANNELS = nn_pkg::NUM_CHANNELS_DEF
) (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,

  // upstream source
  input  logic                                    valid_i,
  output logic                                    ready_o,
  input  logic signed [NUM_CHANNELS*WORD_SIZE-1:0] data_i,

  // per channel bias level
  input  logic signed [NUM_CHANNELS*WORD_SIZE-1:0] bias_i,

  // downstream sink
  output logic                                    valid_o,
  input  logic                                    ready_i,
  output logic signed [NUM_CHANNELS*WORD_SIZE-1:0] data_o
);

  // abs to bias link
  logic                                    mid_valid;
  logic                                    mid_ready;
  logic signed [NUM_CHANNELS*WORD_SIZE-1:0] mid_data;

  // stage one, absolute value
  abs_layer #(
    .WORD_SIZE    (WORD_SIZE),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_abs (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .ready_o  (ready_o),
    .data_i   (data_i),
    .valid_o  (mid_valid),
    .ready_i  (mid_ready),
    .data_o   (mid_data)
  );

  // stage two, bias add
  // two cycle latency end to end when unstalled
  bias_layer #(
    .WORD_SIZE    (WORD_SIZE),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_bias (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (mid_valid),
    .ready_o  (mid_ready),
    .data_i   (mid_data),
    .bias_i   (bias_i),
    .valid_o  (valid_o),
    .ready_i  (ready_i),
    .data_o   (data_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  // free running clock, 40 ns period by default
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // reset held over the first rising edges
  // released on a falling edge, clear of the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/layer_chain_chk.sv
`timescale 1ns/1ps
`default_nettype none

module layer_chain_chk #(
  parameter int WORD_SIZE    = 16,
  parameter int NUM_CHANNELS = 1
) (
  input logic                                    clk_i,
  input logic                                    arst_n_i,
  input logic                                    in_ready_i,
  input logic                                    out_valid_i,
  input logic                                    out_ready_i,
  input logic signed [NUM_CHANNELS*WORD_SIZE-1:0] out_data_i
);

  // failed assertions so far, read back by the testbench
  int fail_cnt = 0;

  // stalled word stays offered
  a_stall_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i |=> out_valid_i)
    else begin
      $error("valid_o dropped while ready_i was low");
      fail_cnt++;
    end

  // and its data does not move
  a_stall_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i |=> $stable(out_data_i))
    else begin
      $error("data_o changed while stalled");
      fail_cnt++;
    end

  // nothing offered under reset
  a_reset_idle: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i)
    else begin
      $error("valid_o high during reset");
      fail_cnt++;
    end

  // empty output stage means the abs stage can always take a word
  a_ready_idle: assert property (@(posedge clk_i) !out_valid_i |-> in_ready_i)
    else begin
      $error("ready_o low while valid_o was low");
      fail_cnt++;
    end

endmodule

bind layer_chain layer_chain_chk #(
  .WORD_SIZE    (WORD_SIZE),
  .NUM_CHANNELS (NUM_CHANNELS)
) u_chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .in_ready_i  (ready_o),
  .out_valid_i (valid_o),
  .out_ready_i (ready_i),
  .out_data_i  (data_o)
);

`default_nettype wire

// File: bench/layer_chain_tb.sv
`timescale 1ns/1ps
`default_nettype none

module layer_chain_tb;

  localparam int WS = nn_pkg::WORD_SIZE_DEF;
  localparam int NC = nn_pkg::NUM_CHANNELS_DEF;
  localparam int VW = WS * NC;

  // words per test
  localparam int N_STREAM = 40;
  localparam int N_EDGE   = 15;
  localparam int N_BIAS   = 30;
  localparam int N_BP     = 60;
  localparam int N_GAP    = 40;
  localparam int N_WORDS  = N_STREAM + N_EDGE + N_BIAS + N_BP + N_GAP;

  // longest idle gap on valid_i and longest low stretch on ready_i
  localparam int MAX_GAP   = 4;
  localparam int MAX_STALL = 8;

  // each word may meet a full gap and a full stall, plus reset and drain slack
  localparam int TIMEOUT_CYC = N_WORDS * (1 + MAX_GAP + MAX_STALL) + 200;

  // at most two words in flight once the sink is ready again
  localparam int DRAIN_CYC = 2 * (MAX_STALL + 2);

  typedef logic signed [VW-1:0] vec_t;
  typedef logic signed [WS-1:0] word_t;

  localparam word_t W_MAX    = {1'b0, {(WS-1){1'b1}}};
  localparam word_t W_MIN    = {1'b1, {(WS-1){1'b0}}};
  localparam word_t W_MIN_P1 = {1'b1, {(WS-2){1'b0}}, 1'b1};

  logic clk;
  logic arst_n;
  logic in_valid;
  logic in_ready;
  vec_t in_data;
  vec_t bias;
  logic out_valid;
  logic out_ready;
  vec_t out_data;

  // stimulus state
  integer seed;
  logic   bp_mode;
  logic   lat_check;
  int     gap_max;
  int     stretch;

  // expected words in flight, with the cycle each was accepted
  vec_t exp_q[$];
  int   acc_q[$];
  int   cyc = 0;

  int data_errs  = 0;
  int level_errs = 0;
  int lat_errs   = 0;
  int proto_errs = 0;
  int asrt_errs  = 0;

  tb_clk_gen #(
    .HALF_PERIOD_NS (20),
    .RESET_CYCLES   (3)
  ) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  layer_chain #(
    .WORD_SIZE    (WS),
    .NUM_CHANNELS (NC)
  ) dut_i (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .valid_i  (in_valid),
    .ready_o  (in_ready),
    .data_i   (in_data),
    .bias_i   (bias),
    .valid_o  (out_valid),
    .ready_i  (out_ready),
    .data_o   (out_data)
  );

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int c = 0; c < NC; c++) begin
      v[c*WS +: WS] = word_t'($random(seed));
    end
    return v;
  endfunction

  function automatic vec_t splat_vec(input word_t w);
    vec_t v;
    for (int c = 0; c < NC; c++) begin
      v[c*WS +: WS] = w;
    end
    return v;
  endfunction

  // min, max, zero and min+1 spread across the channels
  function automatic vec_t mixed_vec();
    vec_t v;
    for (int c = 0; c < NC; c++) begin
      case (c % 4)
        0: v[c*WS +: WS] = W_MIN;
        1: v[c*WS +: WS] = W_MAX;
        2: v[c*WS +: WS] = '0;
        default: v[c*WS +: WS] = W_MIN_P1;
      endcase
    end
    return v;
  endfunction

  // per channel: saturating |x|, then saturating x + bias
  function automatic vec_t expected_vec(input vec_t din, input vec_t bv);
    vec_t   res;
    longint x;
    longint b;
    longint s;
    longint max_v;
    longint min_v;
    max_v = (longint'(1) <<< (WS - 1)) - 1;
    min_v = -max_v - 1;
    for (int c = 0; c < NC; c++) begin
      x = longint'(word_t'(din[c*WS +: WS]));
      b = longint'(word_t'(bv[c*WS +: WS]));
      if (x < 0) begin
        x = -x;
      end
      if (x > max_v) begin
        x = max_v;
      end
      s = x + b;
      if (s > max_v) begin
        s = max_v;
      end else if (s < min_v) begin
        s = min_v;
      end
      res[c*WS +: WS] = word_t'(s);
    end
    return res;
  endfunction

  task automatic check_vec(input string name, input vec_t exp_v, input vec_t act_v);
    if (act_v !== exp_v) begin
      data_errs++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    if (act_b !== exp_b) begin
      level_errs++;
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp_b, act_b);
    end
  endtask

  task automatic check_int(input string name, input int exp_i, input int act_i);
    if (act_i != exp_i) begin
      lat_errs++;
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_i, act_i);
    end
  endtask

  // falling edge, sink ready pattern advances here
  task automatic next_negedge();
    @(negedge clk);
    if (!bp_mode) begin
      out_ready = 1'b1;
      stretch   = 0;
    end else begin
      if (stretch == 0) begin
        out_ready = ~out_ready;
        if (out_ready) begin
          stretch = 1 + rand_below(3);
        end else begin
          stretch = 1 + rand_below(MAX_STALL);
        end
      end
      stretch--;
    end
  endtask

  // offer one word after an optional gap, hold it until taken
  task automatic send_word(input vec_t vec);
    int   gap;
    logic taken;
    gap = (gap_max > 0) ? rand_below(gap_max + 1) : 0;
    repeat (gap) next_negedge();
    in_valid = 1'b1;
    in_data  = vec;
    taken    = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready;
      next_negedge();
    end
    in_valid = 1'b0;
  endtask

  // wait for the queue to empty, but only for a bounded number of cycles
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYC) begin
      next_negedge();
      waited++;
    end
    next_negedge();
  endtask

  task automatic send_edge_set(input vec_t bv);
    bias = bv;
    send_word(splat_vec(W_MIN));
    send_word(splat_vec(W_MAX));
    send_word(splat_vec('0));
    send_word(splat_vec(W_MIN_P1));
    send_word(mixed_vec());
    drain_pipeline();
  endtask

  // scoreboard, sampled on the rising edge
  always @(posedge clk) begin : compare_proc
    vec_t exp_v;
    int   acc;
    if (arst_n) begin
      cyc++;
      if (exp_q.size() == 0) begin
        check_bit("valid_o", 1'b0, out_valid);
      end
      // both registers full and sink stalled is the only way ready_o drops
      check_bit("ready_o", !(exp_q.size() == 2 && !out_ready), in_ready);
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          proto_errs++;
          $display("output word at %0t came with no input word waiting for it", $time);
        end else begin
          exp_v = exp_q.pop_front();
          acc   = acc_q.pop_front();
          check_vec("data_o", exp_v, out_data);
          if (lat_check) begin
            check_int("latency", 2, cyc - acc);
          end
        end
      end
      if (in_valid && in_ready) begin
        exp_q.push_back(expected_vec(in_data, bias));
        acc_q.push_back(cyc);
      end
    end
  end

  initial begin : watchdog_proc
    int wd_cyc;
    wd_cyc = 0;
    while (wd_cyc < TIMEOUT_CYC) begin
      @(posedge clk);
      wd_cyc++;
    end
    $display("run stopped after %0d cycles without finishing", TIMEOUT_CYC);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main_proc
    seed      = 19;
    in_valid  = 1'b0;
    in_data   = '0;
    bias      = '0;
    out_ready = 1'b1;
    bp_mode   = 1'b0;
    lat_check = 1'b1;
    gap_max   = 0;
    stretch   = 0;

    // reset state, during and right after
    repeat (2) next_negedge();
    check_bit("valid_o", 1'b0, out_valid);
    check_bit("ready_o", 1'b1, in_ready);
    @(posedge arst_n);
    next_negedge();
    check_bit("valid_o", 1'b0, out_valid);
    check_bit("ready_o", 1'b1, in_ready);

    // abs only, back to back
    repeat (N_STREAM) send_word(rand_vec());
    drain_pipeline();

    // saturation corners under zero, small and most negative bias
    send_edge_set(splat_vec('0));
    send_edge_set(splat_vec(word_t'(7)));
    send_edge_set(splat_vec(W_MIN));

    // distinct bias on every channel
    bias = rand_vec();
    repeat (N_BIAS) send_word(rand_vec());
    drain_pipeline();

    // sink stalls in long stretches, latency no longer fixed
    lat_check = 1'b0;
    bp_mode   = 1'b1;
    repeat (N_BP) send_word(rand_vec());
    bp_mode = 1'b0;
    drain_pipeline();
    lat_check = 1'b1;

    // idle cycles between words
    gap_max = MAX_GAP;
    repeat (N_GAP) send_word(rand_vec());
    drain_pipeline();
    gap_max = 0;

    if (exp_q.size() != 0) begin
      proto_errs++;
      $display("%0d expected words never left the pipeline", exp_q.size());
    end
    asrt_errs = dut_i.u_chk.fail_cnt;

    $display("error counts: data %0d, handshake %0d, latency %0d, protocol %0d, assertion %0d",
             data_errs, level_errs, lat_errs, proto_errs, asrt_errs);
    if (data_errs + level_errs + lat_errs + proto_errs + asrt_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
src/nn_pkg.sv
src/ctrl_pkg.sv
src/safe_alu.sv
src/single_fifo_ctrl.sv
src/abs_layer.sv
src/bias_layer.sv
src/layer_chain.sv
bench/tb_clk_gen.sv
bench/layer_chain_chk.sv
bench/layer_chain_tb.sv

// File: run.sh
#!/bin/sh
# build the layer chain testbench with verilator and run it
# exits nonzero unless the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --top-module layer_chain_tb \
  --Mdir obj_dir \
  -o layer_chain_sim \
  -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/layer_chain_sim)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "All tests passed"; then
  exit 0
fi

echo "pass line missing from simulation output"
exit 1
